//--- job_sequencer.sv
/*
 * Resample job sequencer
 * Reads the source length header, then alternates one sample read and one
 * sample write per output until the source position runs past the end,
 * and finishes with the output count header and a done pulse
 */
`timescale 1ns/1ps

module job_sequencer import pitch_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         pitch_start,
    input  pitch_job_t   job,
    input  logic         ack,
    input  sample_word_t rdata,
    input  length_t      index,
    input  logic         past_end,
    output mem_cmd_t     cmd,
    output logic         cmd_valid,
    output logic         load,
    output logic         step,
    output logic         pitch_done,
    output length_t      length
);

    seq_state_t  state;
    seq_state_t  next_state;
    sdram_addr_t src_q;
    sdram_addr_t dst_q;
    length_t     count;      // Output words written so far
    logic        pending;    // Sample read in flight

    always_comb begin
        next_state = state;
        cmd        = '0;
        cmd_valid  = 1'b0;
        load       = 1'b0;
        step       = 1'b0;

        case (state)
            IDLE: begin
                if (pitch_start) begin
                    cmd.read   = 1'b1;
                    cmd.addr   = job.src_addr;
                    cmd_valid  = 1'b1;
                    load       = 1'b1;
                    next_state = READ_HEADER;
                end
            end
            READ_HEADER: begin
                if (ack) begin
                    next_state = READ_SAMPLE;    // Length settles first
                end
            end
            READ_SAMPLE: begin
                if (!pending) begin
                    if (past_end) begin
                        cmd.write     = 1'b1;
                        cmd.addr      = dst_q;
                        cmd.writedata = sample_word_t'(count);
                        cmd_valid     = 1'b1;
                        next_state    = WRITE_HEADER;
                    end else begin
                        cmd.read  = 1'b1;
                        cmd.addr  = src_q + sdram_addr_t'(1) + sdram_addr_t'(index);
                        cmd_valid = 1'b1;
                    end
                end else if (ack) begin
                    // Forward the word just read
                    cmd.write     = 1'b1;
                    cmd.addr      = dst_q + sdram_addr_t'(1) + sdram_addr_t'(count);
                    cmd.writedata = rdata;
                    cmd_valid     = 1'b1;
                    next_state    = WRITE_SAMPLE;
                end
            end
            WRITE_SAMPLE: begin
                if (ack) begin
                    step       = 1'b1;
                    next_state = READ_SAMPLE;
                end
            end
            WRITE_HEADER: begin
                if (ack) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= IDLE;
            pending <= 1'b0;
            count   <= '0;
            length  <= '0;
        end else begin
            state <= next_state;

            if (next_state != READ_SAMPLE) begin
                pending <= 1'b0;
            end else if (cmd_valid) begin
                pending <= 1'b1;
            end

            if (load) begin
                count <= '0;
            end else if (step) begin
                count <= count + length_t'(1);
            end

            if (state == READ_HEADER && ack) begin
                length <= rdata[LEN_W-1:0];    // Upper header bits ignored
            end
        end
    end

    // Job addresses, held for the whole run
    always_ff @(posedge i_clk) begin
        if (state == IDLE && pitch_start) begin
            src_q <= job.src_addr;
            dst_q <= job.dst_addr;
        end
    end

    assign pitch_done = (state == FINISH);

    a_done_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst)
        pitch_done |=> !pitch_done
    ) else $error("job_sequencer: pitch_done held longer than one cycle");

endmodule

//--- pitch_pkg.sv
/*
 * Pitch resampler shared definitions
 * Memory word and address types, the fixed-point rate and source position,
 * the job and memory command bundles and the sequencer states
 */
package pitch_pkg;

    localparam int ADDR_W    = 23;    // SDRAM word address
    localparam int WORD_W    = 32;    // One stereo sample or a header
    localparam int LEN_W     = 23;    // Sample count in a header
    localparam int SPEED_W   = 4;
    localparam int FRAC_BITS = 3;     // Speed of 8 is unity

    // Integer part matches the header length
    localparam int PHASE_W   = LEN_W + FRAC_BITS;

    typedef logic [ADDR_W-1:0]  sdram_addr_t;
    typedef logic [WORD_W-1:0]  sample_word_t;
    typedef logic [LEN_W-1:0]   length_t;
    typedef logic [SPEED_W-1:0] speed_t;
    typedef logic [PHASE_W-1:0] phase_t;

    // Captured when a job starts
    typedef struct packed {
        sdram_addr_t src_addr;
        sdram_addr_t dst_addr;
        speed_t      speed;
    } pitch_job_t;

    // One memory access, read or write
    typedef struct packed {
        logic         read;
        logic         write;
        sdram_addr_t  addr;
        sample_word_t writedata;
    } mem_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        READ_SAMPLE,
        WRITE_SAMPLE,
        WRITE_HEADER,
        FINISH
    } seq_state_t;

endpackage

//--- pitch_resampler_top.sv
/*
 * Pitch resampler top level
 * Joins the job sequencer, the phase accumulator and the SDRAM port
 */
`timescale 1ns/1ps

module pitch_resampler_top import pitch_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    // Job control
    input  logic         pitch_start,
    input  sdram_addr_t  pitch_src,
    input  sdram_addr_t  pitch_dst,
    input  speed_t       pitch_speed,
    output logic         pitch_done,
    // SDRAM side
    output logic         pitch_read,
    output logic         pitch_write,
    output sdram_addr_t  pitch_addr,
    output sample_word_t pitch_writedata,
    input  sample_word_t pitch_readdata,
    input  logic         pitch_sdram_finished
);

    pitch_job_t   job;
    mem_cmd_t     cmd;
    logic         cmd_valid;
    logic         ack;
    sample_word_t rdata;
    logic         load;
    logic         step;
    length_t      index;
    length_t      length;
    logic         past_end;

    assign job.src_addr = pitch_src;
    assign job.dst_addr = pitch_dst;
    assign job.speed    = pitch_speed;

    job_sequencer job_sequencer_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .pitch_start (pitch_start),
        .job         (job),
        .ack         (ack),
        .rdata       (rdata),
        .index       (index),
        .past_end    (past_end),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .load        (load),
        .step        (step),
        .pitch_done  (pitch_done),
        .length      (length)
    );

    // Speed is taken in on load only
    resample_phase resample_phase_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .load     (load),
        .step     (step),
        .speed    (job.speed),
        .length   (length),
        .index    (index),
        .past_end (past_end)
    );

    sdram_port sdram_port_inst (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .cmd                  (cmd),
        .cmd_valid            (cmd_valid),
        .pitch_readdata       (pitch_readdata),
        .pitch_sdram_finished (pitch_sdram_finished),
        .pitch_read           (pitch_read),
        .pitch_write          (pitch_write),
        .pitch_addr           (pitch_addr),
        .pitch_writedata      (pitch_writedata),
        .ack                  (ack),
        .rdata                (rdata)
    );

endmodule

//--- resample_phase.sv
/*
 * Resample phase accumulator
 * Tracks the fixed-point source position, advancing by speed/8 per output,
 * and flags when its integer part reaches the header length
 */
`timescale 1ns/1ps

module resample_phase import pitch_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    load,
    input  logic    step,
    input  speed_t  speed,
    input  length_t length,
    output length_t index,
    output logic    past_end
);

    phase_t             phase;
    speed_t             speed_q;
    logic [PHASE_W:0]   phase_sum;    // One carry bit
    phase_t             phase_next;

    // Saturate so that the index never wraps below the length
    always_comb begin
        phase_sum = {1'b0, phase} + {{(PHASE_W + 1 - SPEED_W){1'b0}}, speed_q};
        if (phase_sum[PHASE_W]) begin
            phase_next = '1;
        end else begin
            phase_next = phase_sum[PHASE_W-1:0];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            phase   <= '0;
            speed_q <= '0;
        end else begin
            if (load) begin
                phase   <= '0;
                speed_q <= speed;    // Rate fixed for the whole job
            end else if (step) begin
                phase   <= phase_next;
            end
        end
    end

    assign index    = phase[PHASE_W-1:FRAC_BITS];
    assign past_end = (index >= length);

    // Zero speed would never reach the end of the source
    a_speed_nonzero: assert property (
        @(posedge i_clk) disable iff (i_rst)
        load |-> (speed != '0)
    ) else $error("resample_phase: job started with speed zero");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the pitch resampler testbench with Verilator and runs it.
# Exits nonzero unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_pitch_resampler \
    -Mdir obj_dir -o sim_pitch_resampler
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_pitch_resampler)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1

//--- sdram_port.sv
/*
 * SDRAM access port
 * Takes one command from the sequencer and holds its read or write strobe
 * as a level until the memory reports finished, then latches the read word
 * and pulses ack for one cycle
 */
`timescale 1ns/1ps

module sdram_port import pitch_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  mem_cmd_t     cmd,
    input  logic         cmd_valid,
    input  sample_word_t pitch_readdata,
    input  logic         pitch_sdram_finished,
    output logic         pitch_read,
    output logic         pitch_write,
    output sdram_addr_t  pitch_addr,
    output sample_word_t pitch_writedata,
    output logic         ack,
    output sample_word_t rdata
);

    logic access_open;

    assign access_open = pitch_read | pitch_write;

    // Strobes and ack
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pitch_read  <= 1'b0;
            pitch_write <= 1'b0;
            ack         <= 1'b0;
        end else begin
            if (cmd_valid) begin
                pitch_read  <= cmd.read;
                pitch_write <= cmd.write;
            end else if (access_open && pitch_sdram_finished) begin
                pitch_read  <= 1'b0;    // Drop on the finished edge
                pitch_write <= 1'b0;
            end
            ack <= access_open & pitch_sdram_finished;
        end
    end

    // Address and data stay stable for the whole access
    always_ff @(posedge i_clk) begin
        if (cmd_valid) begin
            pitch_addr      <= cmd.addr;
            pitch_writedata <= cmd.writedata;
        end
        if (pitch_read && pitch_sdram_finished) begin
            rdata <= pitch_readdata;    // Held until the next read
        end
    end

    a_one_strobe: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(pitch_read && pitch_write)
    ) else $error("sdram_port: read and write strobes high together");

    // Sequencer must wait for ack before the next command
    a_no_overlap: assert property (
        @(posedge i_clk) disable iff (i_rst)
        cmd_valid |-> !access_open
    ) else $error("sdram_port: command issued while an access is open");

endmodule

//--- tb_clock.sv
/*
 * Testbench clock generator
 * Free-running clock, low at time zero
 */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- tb_pitch_resampler.sv
/*
 * Pitch resampler testbench
 * Runs resample jobs at several speeds against a behavioral SDRAM model
 * and compares every logged write with a reference of the transfer rule
 */
`timescale 1ns/1ps

module tb_pitch_resampler import pitch_pkg::*; ();

    localparam int PERIOD_NS = 100;
    localparam int IDX_W     = 12;
    localparam int LOG_W     = ADDR_W + WORD_W;

    logic i_clk;
    logic i_rst;
    logic pitch_start;
    sdram_addr_t pitch_src;
    sdram_addr_t pitch_dst;
    speed_t pitch_speed;
    logic pitch_done;
    logic pitch_read;
    logic pitch_write;
    sdram_addr_t pitch_addr;
    sample_word_t pitch_writedata;
    sample_word_t pitch_readdata;
    logic pitch_sdram_finished;
    logic preload_en;
    sdram_addr_t preload_addr;
    sample_word_t preload_data;
    logic bad_access;

    logic [LOG_W-1:0] exp_q [$];    // Expected writes of all jobs, in order
    int mismatch_count = 0;
    int failure_count = 0;
    int unsigned budget_cycles = 0;
    logic budget_ready = 1'b0;

    tb_clock #(.PERIOD_NS(PERIOD_NS)) tb_clock_inst (.clk(i_clk));

    pitch_resampler_top pitch_resampler_top_inst (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .pitch_start          (pitch_start),
        .pitch_src            (pitch_src),
        .pitch_dst            (pitch_dst),
        .pitch_speed          (pitch_speed),
        .pitch_done           (pitch_done),
        .pitch_read           (pitch_read),
        .pitch_write          (pitch_write),
        .pitch_addr           (pitch_addr),
        .pitch_writedata      (pitch_writedata),
        .pitch_readdata       (pitch_readdata),
        .pitch_sdram_finished (pitch_sdram_finished)
    );

    tb_sdram_model mem_model_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .mem_read      (pitch_read),
        .mem_write     (pitch_write),
        .mem_addr      (pitch_addr),
        .mem_writedata (pitch_writedata),
        .preload_en    (preload_en),
        .preload_addr  (preload_addr),
        .preload_data  (preload_data),
        .mem_readdata  (pitch_readdata),
        .mem_finished  (pitch_sdram_finished),
        .bad_access    (bad_access)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    function automatic sample_word_t peek_word(sdram_addr_t a);
        return mem_model_inst.mem[a[IDX_W-1:0]];
    endfunction

    // Reference of the transfer rule, queues the writes of one job
    function automatic void plan_job(sdram_addr_t src, sdram_addr_t dst, speed_t speed);
        sample_word_t header;
        int unsigned  len;
        int unsigned  n;
        int unsigned  pick;
        header = peek_word(src);
        len    = 32'(header[LEN_W-1:0]);
        n      = 0;
        pick   = 0;
        while (pick < len) begin
            exp_q.push_back({dst + sdram_addr_t'(1 + n), peek_word(src + sdram_addr_t'(1 + pick))});
            n++;
            pick = (n * 32'(speed)) >> FRAC_BITS;    // floor(n * speed / 8)
        end
        exp_q.push_back({dst, n});
        budget_cycles += 10 * (2 * n + 4);
    endfunction

    task automatic set_header(input sdram_addr_t addr, input sample_word_t word);
        @(posedge i_clk);
        #1;
        preload_en   = 1'b1;
        preload_addr = addr;
        preload_data = word;
        @(posedge i_clk);
        #1;
        preload_en   = 1'b0;
    endtask

    task automatic run_job(input sdram_addr_t src, input sdram_addr_t dst, input speed_t speed,
                           input logic hold_start);
        @(posedge i_clk);
        #1;
        pitch_start = 1'b1;
        pitch_src   = src;
        pitch_dst   = dst;
        pitch_speed = speed;
        if (!hold_start) begin
            @(posedge i_clk);
            #1;
            pitch_start = 1'b0;
        end
        do begin
            @(negedge i_clk);
        end while (!pitch_done);
        @(posedge i_clk);
        #1;
        pitch_start = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin : stimulus
        i_rst        = 1'b1;
        pitch_start  = 1'b0;
        pitch_src    = '0;
        pitch_dst    = '0;
        pitch_speed  = '0;
        preload_en   = 1'b0;
        preload_addr = '0;
        preload_data = '0;
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        set_header(23'h010, 32'd12);
        set_header(23'h040, {9'h1A5, 23'd16});    // Upper bits must be ignored
        set_header(23'h080, 32'd10);
        set_header(23'h0C0, 32'd0);
        set_header(23'h100, 32'd6);
        set_header(23'h140, 32'd20);

        plan_job(23'h010, 23'h400, 4'd8);
        plan_job(23'h040, 23'h500, 4'd12);
        plan_job(23'h080, 23'h600, 4'd5);
        plan_job(23'h0C0, 23'h700, 4'd8);
        plan_job(23'h100, 23'h800, 4'd3);
        plan_job(23'h140, 23'h900, 4'd15);
        budget_ready = 1'b1;

        // Quiet bus before the first start
        repeat (8) begin
            @(negedge i_clk);
            check_value("pitch_read", 32'(pitch_read), 32'd0);
            check_value("pitch_write", 32'(pitch_write), 32'd0);
            check_value("pitch_done", 32'(pitch_done), 32'd0);
        end

        run_job(23'h010, 23'h400, 4'd8, 1'b0);
        run_job(23'h040, 23'h500, 4'd12, 1'b0);
        if (peek_word(23'h500) >= 32'd16) begin
            failure_count++;
            $display("speed 12 wrote a header of %0d, expected fewer than the length 16",
                     peek_word(23'h500));
        end
        run_job(23'h080, 23'h600, 4'd5, 1'b0);
        if (peek_word(23'h600) <= 32'd10) begin
            failure_count++;
            $display("speed 5 wrote a header of %0d, expected more than the length 10",
                     peek_word(23'h600));
        end
        run_job(23'h0C0, 23'h700, 4'd8, 1'b0);
        run_job(23'h100, 23'h800, 4'd3, 1'b0);
        run_job(23'h140, 23'h900, 4'd15, 1'b1);    // Start held for the whole job

        repeat (10) @(negedge i_clk);
        if (exp_q.size() != 0) begin
            failure_count++;
            $display("%0d expected writes never arrived", exp_q.size());
        end
        if (bad_access) begin
            failure_count++;
            $display("the DUT accessed an address outside the memory model");
        end
        finish_run();
    end

    initial begin : compare_writes
        logic [LOG_W-1:0] got;
        logic [LOG_W-1:0] expected;
        forever begin
            @(negedge i_clk);
            while (mem_model_inst.wr_log_q.size() > 0) begin
                got = mem_model_inst.wr_log_q.pop_front();
                if (exp_q.size() == 0) begin
                    failure_count++;
                    $display("unexpected write at %0t to address %h", $time,
                             got[LOG_W-1:WORD_W]);
                end else begin
                    expected = exp_q.pop_front();
                    check_value("pitch_addr", 32'(got[LOG_W-1:WORD_W]),
                                32'(expected[LOG_W-1:WORD_W]));
                    check_value("pitch_writedata", got[WORD_W-1:0], expected[WORD_W-1:0]);
                end
            end
        end
    end

    initial begin : watchdog
        wait (budget_ready);
        repeat (budget_cycles) @(posedge i_clk);
        failure_count++;
        $display("timeout: the jobs did not finish within %0d cycles", budget_cycles);
        finish_run();
    end

endmodule

//--- tb_sdram_model.sv
/*
 * Behavioral SDRAM word memory
 * Answers each read or write strobe with a finished pulse after a random
 * latency of 1 to 4 cycles and logs every write as {address, data}
 */
`timescale 1ns/1ps

module tb_sdram_model import pitch_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         mem_read,
    input  logic         mem_write,
    input  sdram_addr_t  mem_addr,
    input  sample_word_t mem_writedata,
    input  logic         preload_en,
    input  sdram_addr_t  preload_addr,
    input  sample_word_t preload_data,
    output sample_word_t mem_readdata,
    output logic         mem_finished,
    output logic         bad_access
);

    localparam int MEM_WORDS = 4096;
    localparam int IDX_W     = 12;
    localparam int LOG_W     = ADDR_W + WORD_W;

    sample_word_t     mem [MEM_WORDS];
    logic [LOG_W-1:0] wr_log_q [$];
    integer           seed = 72;
    logic             active;       // Strobe seen, finished not yet given
    int unsigned      wait_cnt;

    // Every word differs and carries its full address
    function automatic sample_word_t fill_word(sdram_addr_t a);
        return 32'hC300_0000 ^ {a, 9'h000} ^ {9'h000, a};
    endfunction

    function automatic logic in_range(sdram_addr_t a);
        return a < sdram_addr_t'(MEM_WORDS);
    endfunction

    always @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i[IDX_W-1:0]] = fill_word(sdram_addr_t'(i));
            end
            mem_readdata <= '0;
            mem_finished <= 1'b0;
            bad_access   <= 1'b0;
            active       <= 1'b0;
            wait_cnt     <= 0;
        end else begin
            mem_finished <= 1'b0;
            if (preload_en && in_range(preload_addr)) begin
                mem[preload_addr[IDX_W-1:0]] = preload_data;
            end
            if (mem_finished) begin
                active <= 1'b0;    // Strobe drops on this edge
            end else if ((mem_read || mem_write) && !active) begin
                active   <= 1'b1;
                wait_cnt <= 1 + ($unsigned($random(seed)) % 4);
            end else if (active) begin
                if (wait_cnt == 1) begin
                    mem_finished <= 1'b1;
                    if (!in_range(mem_addr)) begin
                        bad_access <= 1'b1;
                    end else if (mem_write) begin
                        mem[mem_addr[IDX_W-1:0]] = mem_writedata;
                        wr_log_q.push_back({mem_addr, mem_writedata});
                    end else begin
                        mem_readdata <= mem[mem_addr[IDX_W-1:0]];
                    end
                end
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

//--- verilog.f
pitch_pkg.sv
sdram_port.sv
resample_phase.sv
job_sequencer.sv
pitch_resampler_top.sv
tb_clock.sv
tb_sdram_model.sv
tb_pitch_resampler.sv
